// File: logic/ciPkg.sv
// custom-instruction package
// instruction field positions, register selector and the DMA settings
// shared by the CPU decode, the register file and the DMA engine
package ciPkg;

    // ciN value this block answers to
    localparam logic [7:0] customId = 8'h0E;

    // local SRAM depth in words
    localparam int sramDepth = 512;

    // valueA layout
    localparam int selectMsb = 12;
    localparam int selectLsb = 10;
    localparam int writeBit = 9;

    // CPU operand and result word
    typedef logic [31:0] ciWord;

    // local SRAM word address
    typedef logic [8:0] sramAddr;

    // DMA transfer length in words
    typedef logic [9:0] blockSize;

    // target of a CPU access, valueA bits 12..10
    typedef enum logic [2:0] {
        selMemory     = 3'd0,
        selBusStart   = 3'd1,
        selMemStart   = 3'd2,
        selBlockSize  = 3'd3,
        selBurstSize  = 3'd4,
        selCtrlStatus = 3'd5
    } regSelect;

    // settings handed to the DMA engine
    typedef struct packed {
        ciWord      busStart;
        sramAddr    memStart;
        blockSize   blockLen;
        // burst length minus one
        logic [7:0] burstLen;
        // single-cycle launch strobes
        logic       startRead;
        logic       startWrite;
    } dmaConfig;

    // engine state seen by the register file
    typedef struct packed {
        logic busy;
        // one-cycle pulse when the bus reported an error
        logic error;
    } dmaStatus;

endpackage

// File: logic/busPkg.sv
// system bus package
// address/data and burst types plus the master-side signal bundles
package busPkg;

    // byte step between consecutive bus words
    localparam int wordBytes = 4;

    // multiplexed address/data word
    typedef logic [31:0] busWord;

    // burst length minus one
    typedef logic [7:0] burstCount;

    // what the bus drives into this block
    typedef struct packed {
        logic   grant;
        busWord addressData;
        logic   endTransaction;
        logic   dataValid;
        // slave back-pressure
        logic   busy;
        logic   error;
    } busIn;

    // what this block drives onto the bus
    typedef struct packed {
        logic      request;
        busWord    addressData;
        burstCount burstSize;
        logic      readNotWrite;
        logic      beginTransaction;
        logic      endTransaction;
        logic      dataValid;
        // slave-side fields, tied low since this block is master only
        logic      busy;
        logic      error;
    } busOut;

endpackage

// File: logic/dualPortSsram.sv
// dual-port synchronous SRAM, 512 x 32
// port A serves the CPU, port B the DMA engine; both read registered,
// a read of the address being written returns the old word
`timescale 1ns/1ps

module dualPortSsram (
    input  logic           clock,
    input  logic           weA,
    input  ciPkg::sramAddr addrA,
    input  ciPkg::ciWord   dataInA,
    output ciPkg::ciWord   dataOutA,
    input  logic           weB,
    input  ciPkg::sramAddr addrB,
    input  ciPkg::ciWord   dataInB,
    output ciPkg::ciWord   dataOutB
);

    ciPkg::ciWord mem [ciPkg::sramDepth];

    // both ports on the same edge
    always_ff @(posedge clock) begin
        if (weA) begin
            mem[addrA] <= dataInA;
        end
        if (weB) begin
            mem[addrB] <= dataInB;
        end
        // old data on a same-address write
        dataOutA <= mem[addrA];
        dataOutB <= mem[addrB];
    end

    // CPU and DMA never write one word together
    assert property (@(posedge clock) !(weA && weB && addrA == addrB))
        else $error("dual write to SRAM address %0d", addrA);

endmodule

// File: logic/dmaRegisters.sv
// DMA configuration registers
// holds the transfer settings, turns control writes into launch strobes,
// keeps the error flag and builds the zero-extended read-back word
`timescale 1ns/1ps

module dmaRegisters (
    input  logic            clock,
    input  logic            rst,
    input  logic            access,
    input  ciPkg::regSelect select,
    input  logic            write,
    input  ciPkg::ciWord    writeData,
    output ciPkg::ciWord    readData,
    output ciPkg::dmaConfig cfg,
    input  ciPkg::dmaStatus status
);

    ciPkg::ciWord    busStartReg;
    ciPkg::sramAddr  memStartReg;
    ciPkg::blockSize blockLenReg;
    logic [7:0]      burstLenReg;
    logic            errorFlag;
    logic            regWrite;
    logic            ctrlWrite;
    logic            errorBit;

    assign regWrite = access && write;
    assign ctrlWrite = regWrite && select == ciPkg::selCtrlStatus;

    // settings truncated to field width
    always_ff @(posedge clock) begin
        if (rst) begin
            busStartReg <= '0;
            memStartReg <= '0;
            blockLenReg <= '0;
            burstLenReg <= '0;
        end else if (regWrite) begin
            case (select)
                ciPkg::selBusStart:  busStartReg <= writeData;
                ciPkg::selMemStart:  memStartReg <= writeData[8:0];
                ciPkg::selBlockSize: blockLenReg <= writeData[9:0];
                ciPkg::selBurstSize: burstLenReg <= writeData[7:0];
                default: ;
            endcase
        end
    end

    // error sticks until the next control write
    always_ff @(posedge clock) begin
        if (rst) begin
            errorFlag <= 1'b0;
        end else if (ctrlWrite) begin
            errorFlag <= 1'b0;
        end else if (status.error) begin
            errorFlag <= 1'b1;
        end
    end

    // engine pulse counts before the flag catches it
    assign errorBit = errorFlag || status.error;

    always_comb begin
        cfg.busStart = busStartReg;
        cfg.memStart = memStartReg;
        cfg.blockLen = blockLenReg;
        cfg.burstLen = burstLenReg;
        // launch only when idle
        // bit 0 wins over bit 1
        cfg.startRead = ctrlWrite && !status.busy && writeData[0];
        cfg.startWrite = ctrlWrite && !status.busy && !writeData[0] && writeData[1];
    end

    // read-back with busy in status bit 0 and error in bit 1
    always_comb begin
        case (select)
            ciPkg::selBusStart:   readData = busStartReg;
            ciPkg::selMemStart:   readData = {23'd0, memStartReg};
            ciPkg::selBlockSize:  readData = {22'd0, blockLenReg};
            ciPkg::selBurstSize:  readData = {24'd0, burstLenReg};
            ciPkg::selCtrlStatus: readData = {30'd0, errorBit, status.busy};
            default:              readData = '0;
        endcase
    end

    // a launch of a non-empty block must make the engine busy
    assert property (@(posedge clock) disable iff (rst)
        (cfg.startRead || cfg.startWrite) && cfg.blockLen != '0 |=> status.busy)
        else $error("DMA launch not taken by the engine");

endmodule

// File: logic/dmaBusMaster.sv
// DMA bus master
// splits a block into bursts and moves words between the system bus and
// SRAM port B in either direction, honoring slave back-pressure and errors
`timescale 1ns/1ps

module dmaBusMaster (
    input  logic            clock,
    input  logic            rst,
    input  ciPkg::dmaConfig cfg,
    output ciPkg::dmaStatus status,
    output ciPkg::sramAddr  sramAddr,
    output logic            sramWe,
    output ciPkg::ciWord    sramWrData,
    input  ciPkg::ciWord    sramRdData,
    input  busPkg::busIn    busIn,
    output busPkg::busOut   busOut
);

    typedef enum logic [2:0] {
        sIdle,
        sBegin,
        sRequest,
        sReadData,
        sWriteData,
        sWriteEnd,
        sNextBurst
    } dmaState;

    dmaState           state;
    busPkg::busWord    busAddr;
    ciPkg::sramAddr    memAddr;
    ciPkg::blockSize   wordsLeft;
    logic [8:0]        burstLeft;
    busPkg::burstCount burstLen;
    logic              isRead;
    logic              errorSeen;
    logic              launch;
    logic              granted;
    logic              wordIn;
    logic              wordOut;
    logic [9:0]        maxBurst;
    logic [9:0]        burstWords;

    // empty blocks never leave idle
    assign launch = state == sIdle && (cfg.startRead || cfg.startWrite)
                    && cfg.blockLen != '0;
    // first grant cycle carries the address phase
    assign granted = state == sRequest && busIn.grant;
    // incoming read word
    assign wordIn = state == sReadData && busIn.dataValid && burstLeft != '0;
    // outgoing word taken by the slave
    assign wordOut = state == sWriteData && !busIn.busy;

    // last burst shortened to what remains
    assign maxBurst = 10'(burstLen) + 10'd1;
    assign burstWords = (wordsLeft > maxBurst) ? maxBurst : wordsLeft;

    // look one word ahead once the current one is accepted
    assign sramAddr = wordOut ? memAddr + 1'b1 : memAddr;
    assign sramWe = wordIn;
    assign sramWrData = busIn.addressData;

    assign status.busy = state != sIdle;
    assign status.error = errorSeen;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= sIdle;
            errorSeen <= 1'b0;
        end else begin
            errorSeen <= 1'b0;
            if (state != sIdle && busIn.error) begin
                // abandon the block and drop request at once
                state <= sIdle;
                errorSeen <= 1'b1;
            end else begin
                case (state)
                    sIdle: begin
                        if (launch) begin
                            state <= sBegin;
                        end
                    end
                    sBegin: state <= sRequest;
                    sRequest: begin
                        if (busIn.grant) begin
                            state <= isRead ? sReadData : sWriteData;
                        end
                    end
                    sReadData: begin
                        if (busIn.endTransaction) begin
                            state <= sNextBurst;
                        end
                    end
                    sWriteData: begin
                        if (wordOut && burstLeft == 9'd1) begin
                            state <= sWriteEnd;
                        end
                    end
                    sWriteEnd: state <= sNextBurst;
                    sNextBurst: state <= (wordsLeft == '0) ? sIdle : sBegin;
                    default: state <= sIdle;
                endcase
            end
        end
    end

    // word pointers and counters
    always_ff @(posedge clock) begin
        if (rst) begin
            memAddr <= '0;
            wordsLeft <= '0;
            burstLeft <= '0;
        end else if (launch) begin
            memAddr <= cfg.memStart;
            wordsLeft <= cfg.blockLen;
        end else if (state == sBegin) begin
            burstLeft <= burstWords[8:0];
        end else if (wordIn || wordOut) begin
            memAddr <= memAddr + 1'b1;
            wordsLeft <= wordsLeft - 1'b1;
            burstLeft <= burstLeft - 1'b1;
        end
    end

    // bus address and transfer settings
    always_ff @(posedge clock) begin
        if (launch) begin
            busAddr <= cfg.busStart;
            burstLen <= cfg.burstLen;
            isRead <= cfg.startRead;
        end else if (wordIn || wordOut) begin
            busAddr <= busAddr + busPkg::busWord'(busPkg::wordBytes);
        end
    end

    always_comb begin
        busOut = '0;
        busOut.request = state == sRequest;
        busOut.beginTransaction = granted;
        busOut.readNotWrite = granted && isRead;
        if (granted) begin
            busOut.addressData = busAddr;
            busOut.burstSize = busPkg::burstCount'(burstLeft - 9'd1);
        end else if (state == sWriteData) begin
            // held while the slave is busy
            busOut.addressData = sramRdData;
        end
        busOut.dataValid = state == sWriteData;
        busOut.endTransaction = state == sWriteEnd;
    end

    // a finished burst has moved every word it announced
    assert property (@(posedge clock) disable iff (rst)
        state == sNextBurst |-> burstLeft == '0)
        else $error("burst ended with words outstanding");

endmodule

// File: logic/ramDmaCi.sv
// RAM/DMA custom instruction, top level
// decodes CPU requests into local SRAM or DMA register accesses and
// answers with done/result; the DMA engine moves blocks to the system bus
`timescale 1ns/1ps

module ramDmaCi (
    input  logic          clock,
    input  logic          rst,
    input  logic          start,
    input  logic [7:0]    ciN,
    input  ciPkg::ciWord  valueA,
    input  ciPkg::ciWord  valueB,
    output logic          done,
    output ciPkg::ciWord  result,
    input  busPkg::busIn  busIn,
    output busPkg::busOut busOut
);

    ciPkg::regSelect select;
    ciPkg::sramAddr  cpuAddr;
    logic            writeReq;
    logic            isMine;
    logic            memWrite;
    logic            memRead;
    logic            regAccess;
    logic            readPending;
    ciPkg::ciWord    sramDataA;
    ciPkg::ciWord    regReadData;
    ciPkg::dmaConfig dmaCfg;
    ciPkg::dmaStatus dmaStat;
    ciPkg::sramAddr  dmaAddr;
    logic            dmaWe;
    ciPkg::ciWord    dmaWrData;
    ciPkg::ciWord    dmaRdData;

    // request fields
    assign select = ciPkg::regSelect'(valueA[ciPkg::selectMsb:ciPkg::selectLsb]);
    assign writeReq = valueA[ciPkg::writeBit];
    assign cpuAddr = valueA[8:0];

    // only our own custom id
    assign isMine = start && ciN == ciPkg::customId;
    assign memWrite = isMine && select == ciPkg::selMemory && writeReq;
    assign memRead = isMine && select == ciPkg::selMemory && !writeReq;
    assign regAccess = isMine && select != ciPkg::selMemory;

    // SRAM read data arrives one cycle late
    always_ff @(posedge clock) begin
        if (rst) begin
            readPending <= 1'b0;
        end else begin
            readPending <= memRead;
        end
    end

    // everything except a memory read answers in the start cycle
    assign done = readPending || (isMine && !memRead);

    always_comb begin
        if (readPending) begin
            result = sramDataA;
        end else if (regAccess && !writeReq) begin
            result = regReadData;
        end else begin
            result = '0;
        end
    end

    dualPortSsram sram (
        .clock    (clock),
        .weA      (memWrite),
        .addrA    (cpuAddr),
        .dataInA  (valueB),
        .dataOutA (sramDataA),
        .weB      (dmaWe),
        .addrB    (dmaAddr),
        .dataInB  (dmaWrData),
        .dataOutB (dmaRdData)
    );

    dmaRegisters regs (
        .clock     (clock),
        .rst       (rst),
        .access    (regAccess),
        .select    (select),
        .write     (writeReq),
        .writeData (valueB),
        .readData  (regReadData),
        .cfg       (dmaCfg),
        .status    (dmaStat)
    );

    dmaBusMaster dma (
        .clock      (clock),
        .rst        (rst),
        .cfg        (dmaCfg),
        .status     (dmaStat),
        .sramAddr   (dmaAddr),
        .sramWe     (dmaWe),
        .sramWrData (dmaWrData),
        .sramRdData (dmaRdData),
        .busIn      (busIn),
        .busOut     (busOut)
    );

    // CPU waits for a memory read before the next start
    assert property (@(posedge clock) disable iff (rst) memRead |=> !start)
        else $error("start issued while a memory read is pending");

endmodule

// File: sim/tbClock.sv
// testbench clock and reset
// 40 ns clock, synchronous reset held high over the first two rising edges
`timescale 1ns/1ps

module tbClock (
    output logic clock,
    output logic rst
);

    localparam int halfPeriod = 20;

    initial begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    // released just after the second rising edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clock);
        #2 rst = 1'b0;
    end

endmodule

// File: sim/ramDmaCiChecker.sv
// response checker for the RAM/DMA custom instruction
// matches every done/result against the queued expected responses,
// also takes value checks from the bus slave and keeps the error count
`timescale 1ns/1ps

module ramDmaCiChecker (
    input logic         clock,
    input logic         rst,
    input logic         done,
    input ciPkg::ciWord result
);

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    // pending responses, oldest first
    string        names [$];
    int           dueCycles [$];
    logic         cares [$];
    ciPkg::ciWord values [$];

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic expectDone(input string name, input int due, input logic care,
                              input ciPkg::ciWord value);
        names.push_back(name);
        dueCycles.push_back(due);
        cares.push_back(care);
        values.push_back(value);
    endtask

    task automatic dropFront();
        names.delete(0);
        dueCycles.delete(0);
        cares.delete(0);
        values.delete(0);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic reportProblem(input string msg);
        errors++;
        $display("ERROR at cycle %0d: %s", cycle, msg);
    endtask

    // sampled mid-cycle, well after the inputs settle
    always @(negedge clock) begin
        if (!rst) begin
            if (dueCycles.size() != 0 && dueCycles[0] < cycle) begin
                reportProblem($sformatf("no done for %s", names[0]));
                dropFront();
            end
            if (done === 1'b1 && dueCycles.size() != 0 && dueCycles[0] == cycle) begin
                // polls only check the timing
                if (cares[0]) begin
                    checkValue(names[0], values[0], result);
                end
                dropFront();
            end else if (done !== 1'b0) begin
                reportProblem("done high outside an expected response");
            end else if (result !== '0) begin
                reportProblem("result not zero while done is low");
            end
        end
    end

    task automatic printCounts();
        if (dueCycles.size() != 0) begin
            reportProblem($sformatf("%0d responses never arrived", dueCycles.size()));
        end
        $display("checks %0d, errors %0d", checks, errors);
    endtask

endmodule

// File: sim/ramDmaCiTb.sv
// testbench for the RAM/DMA custom instruction
// drives CPU requests, plays a bursting bus slave with its own memory
// and keeps a model of the SRAM and the DMA registers
`timescale 1ns/1ps

module ramDmaCiTb;

    logic          clock;
    logic          rst;
    logic          start;
    logic [7:0]    ciN;
    ciPkg::ciWord  valueA;
    ciPkg::ciWord  valueB;
    logic          done;
    ciPkg::ciWord  result;
    busPkg::busIn  slaveBus;
    busPkg::busOut masterBus;

    // reference model
    ciPkg::ciWord   ramModel [512];
    ciPkg::ciWord   regModel [8];
    logic           errModel;
    busPkg::busWord slaveMem [1024];
    // burst splitting expected by the slave
    busPkg::busWord expAddr;
    int             remain;
    int             burstModel;
    logic           expRead;
    logic           injectError;
    logic [15:0]    lfsr = 16'd55860;

    tbClock clk (.clock(clock), .rst(rst));

    ramDmaCi uut (
        .clock  (clock),
        .rst    (rst),
        .start  (start),
        .ciN    (ciN),
        .valueA (valueA),
        .valueB (valueB),
        .done   (done),
        .result (result),
        .busIn  (slaveBus),
        .busOut (masterBus)
    );

    ramDmaCiChecker chk (.clock(clock), .rst(rst), .done(done), .result(result));

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic ciPkg::ciWord requestWord(input ciPkg::regSelect sel, input logic wr,
                                                 input ciPkg::sramAddr addr);
        return {19'd0, sel, wr, addr};
    endfunction

    function automatic ciPkg::ciWord fieldMask(input ciPkg::regSelect sel);
        case (sel)
            ciPkg::selMemStart:  return 32'h0000_01FF;
            ciPkg::selBlockSize: return 32'h0000_03FF;
            ciPkg::selBurstSize: return 32'h0000_00FF;
            default:             return 32'hFFFF_FFFF;
        endcase
    endfunction

    // byte address to slave word
    function automatic int slaveIndex(input busPkg::busWord addr);
        return int'((addr >> 2) & 32'd1023);
    endfunction

    // one CPU instruction with the result sampled where done is due
    task automatic cpuOp(input string name, input logic [7:0] id, input ciPkg::ciWord a,
                         input ciPkg::ciWord b, input logic care, input ciPkg::ciWord expVal,
                         output ciPkg::ciWord got);
        logic memRd;
        memRd = ciPkg::regSelect'(a[ciPkg::selectMsb:ciPkg::selectLsb]) == ciPkg::selMemory
                && !a[ciPkg::writeBit];
        @(posedge clock);
        #2;
        start = 1'b1;
        ciN = id;
        valueA = a;
        valueB = b;
        if (id == ciPkg::customId) begin
            chk.expectDone(name, chk.cycle + memRd, care, expVal);
        end
        @(negedge clock);
        got = result;
        @(posedge clock);
        #2;
        start = 1'b0;
        // memory reads answer one cycle late
        if (memRd) begin
            @(negedge clock);
            got = result;
        end
    endtask

    // own-id access checked against the model
    task automatic ciAccess(input string name, input ciPkg::regSelect sel, input logic wr,
                            input ciPkg::sramAddr addr, input ciPkg::ciWord data);
        ciPkg::ciWord expVal;
        ciPkg::ciWord got;
        expVal = '0;
        if (wr) begin
            if (sel == ciPkg::selMemory) begin
                ramModel[addr] = data;
            end else if (sel == ciPkg::selCtrlStatus) begin
                errModel = 1'b0;
            end else begin
                regModel[sel] = data & fieldMask(sel);
            end
        end else if (sel == ciPkg::selMemory) begin
            expVal = ramModel[addr];
        end else if (sel == ciPkg::selCtrlStatus) begin
            expVal = {30'd0, errModel, 1'b0};
        end else begin
            expVal = regModel[sel];
        end
        cpuOp(name, ciPkg::customId, requestWord(sel, wr, addr), data, 1'b1, expVal, got);
    endtask

    // configure, launch, then poll status until busy falls
    task automatic runDma(input string name, input logic toSram, input busPkg::busWord busStart,
                          input ciPkg::sramAddr memStart, input int len, input int burst);
        ciPkg::ciWord got;
        ciAccess("bus start write", ciPkg::selBusStart, 1'b1, '0, busStart);
        ciAccess("mem start write", ciPkg::selMemStart, 1'b1, '0, 32'(memStart));
        ciAccess("block size write", ciPkg::selBlockSize, 1'b1, '0, 32'(len));
        ciAccess("burst size write", ciPkg::selBurstSize, 1'b1, '0, 32'(burst));
        expAddr = busStart;
        remain = len;
        burstModel = burst;
        expRead = toSram;
        ciAccess({name, " launch"}, ciPkg::selCtrlStatus, 1'b1, '0, toSram ? 32'd1 : 32'd2);
        got = 32'd1;
        while (got[0]) begin
            cpuOp("status poll", ciPkg::customId, requestWord(ciPkg::selCtrlStatus, 1'b0, '0),
                  '0, 1'b0, '0, got);
        end
        if (!injectError) begin
            chk.checkValue({name, " words left"}, 0, remain);
        end
    endtask

    // bus slave that grants after a random delay and serves one burst per grant
    initial begin : busSlave
        busPkg::busWord addr;
        int             count;
        int             k;
        int             errAt;
        logic           isRead;
        logic           aborted;
        slaveBus = '0;
        forever begin
            @(negedge clock);
            if (masterBus.request === 1'b1) begin
                repeat (randBits(2)) @(negedge clock);
                @(posedge clock);
                #2 slaveBus.grant = 1'b1;
                @(negedge clock);
                addr = masterBus.addressData;
                count = masterBus.burstSize + 1;
                isRead = masterBus.readNotWrite;
                chk.checkValue("begin pulse", 1, masterBus.beginTransaction);
                chk.checkValue("burst direction", expRead, isRead);
                chk.checkValue("burst address", expAddr, addr);
                chk.checkValue("burst length", (remain > burstModel) ? burstModel + 1 : remain,
                               count);
                errAt = injectError ? int'(randBits(4)) % count : -1;
                aborted = 1'b0;
                @(posedge clock);
                #2 slaveBus.grant = 1'b0;
                if (isRead) begin
                    for (k = 0; k < count && !aborted; k++) begin
                        if (k == errAt) begin
                            slaveBus = '0;
                            slaveBus.error = 1'b1;
                            aborted = 1'b1;
                        end else begin
                            slaveBus.dataValid = 1'b1;
                            slaveBus.addressData = slaveMem[slaveIndex(addr)];
                            // end marks the last word
                            slaveBus.endTransaction = k == count - 1;
                            addr = addr + 4;
                        end
                        @(posedge clock);
                        #2;
                    end
                    slaveBus = '0;
                end else begin
                    k = 0;
                    while (k < count) begin
                        // back-pressure about one cycle in four
                        slaveBus.busy = randBits(2) == 2'd0;
                        @(negedge clock);
                        if (masterBus.dataValid !== 1'b1) begin
                            chk.reportProblem("write burst stopped before its last word");
                            k = count;
                        end else if (!slaveBus.busy) begin
                            slaveMem[slaveIndex(addr)] = masterBus.addressData;
                            addr = addr + 4;
                            k++;
                        end
                        @(posedge clock);
                        #2;
                    end
                    slaveBus.busy = 1'b0;
                    @(negedge clock);
                    chk.checkValue("write end pulse", 1, masterBus.endTransaction);
                end
                expAddr = expAddr + 4 * count;
                remain = remain - count;
            end
        end
    end

    initial begin : stimulus
        ciPkg::sramAddr written [200];
        ciPkg::sramAddr memStart;
        busPkg::busWord busStart;
        ciPkg::ciWord   got;
        logic [7:0]     foreignId;
        int             len;
        start = 1'b0;
        ciN = '0;
        valueA = '0;
        valueB = '0;
        injectError = 1'b0;
        errModel = 1'b0;
        for (int i = 0; i < 8; i++) begin
            regModel[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            slaveMem[i] = randBits(32);
        end
        while (rst !== 1'b0) @(posedge clock);

        // reset state
        @(negedge clock);
        chk.checkValue("reset request", 0, masterBus.request);
        chk.checkValue("reset data valid", 0, masterBus.dataValid);
        chk.checkValue("reset begin", 0, masterBus.beginTransaction);
        chk.checkValue("reset end", 0, masterBus.endTransaction);
        chk.checkValue("reset bus busy", 0, masterBus.busy);
        chk.checkValue("reset bus error", 0, masterBus.error);
        for (int s = 1; s <= 5; s++) begin
            ciAccess("reset readback", ciPkg::regSelect'(s), 1'b0, '0, '0);
        end

        // CPU memory traffic
        for (int i = 0; i < 200; i++) begin
            written[i] = 9'(randBits(9));
            ciAccess("memory write", ciPkg::selMemory, 1'b1, written[i], randBits(32));
        end
        for (int i = 0; i < 200; i++) begin
            ciAccess("memory read", ciPkg::selMemory, 1'b0, written[i], '0);
        end

        // register read-back and foreign ids that must change nothing
        for (int s = 1; s <= 4; s++) begin
            ciAccess("register write", ciPkg::regSelect'(s), 1'b1, '0, randBits(32));
            ciAccess("register readback", ciPkg::regSelect'(s), 1'b0, '0, '0);
        end
        foreignId = ciPkg::customId + 8'(randBits(7) + 1);
        for (int s = 1; s <= 4; s++) begin
            cpuOp("foreign write", foreignId, requestWord(ciPkg::regSelect'(s), 1'b1, '0),
                  randBits(32), 1'b0, '0, got);
        end
        cpuOp("foreign memory write", foreignId,
              requestWord(ciPkg::selMemory, 1'b1, written[0]), ~ramModel[written[0]],
              1'b0, '0, got);
        for (int s = 1; s <= 4; s++) begin
            ciAccess("register after foreign", ciPkg::regSelect'(s), 1'b0, '0, '0);
        end
        ciAccess("memory after foreign", ciPkg::selMemory, 1'b0, written[0], '0);

        // bus to SRAM
        busStart = busPkg::busWord'(randBits(10)) << 2;
        memStart = 9'(randBits(9));
        len = randBits(6) + 1;
        runDma("bus to sram", 1'b1, busStart, memStart, len, randBits(4));
        for (int i = 0; i < len; i++) begin
            ramModel[9'(memStart + i)] = slaveMem[slaveIndex(busStart + 4 * i)];
        end
        for (int i = 0; i < len; i++) begin
            ciAccess("dma read data", ciPkg::selMemory, 1'b0, 9'(memStart + i), '0);
        end

        // same SRAM block back out to a new bus address
        busStart = busPkg::busWord'(randBits(10)) << 2;
        runDma("sram to bus", 1'b0, busStart, memStart, len, randBits(4));
        for (int i = 0; i < len; i++) begin
            chk.checkValue("dma write data", ramModel[9'(memStart + i)],
                           slaveMem[slaveIndex(busStart + 4 * i)]);
        end

        // error in the first burst abandons the block
        injectError = 1'b1;
        runDma("bus error", 1'b1, busPkg::busWord'(randBits(10)) << 2, 9'(randBits(9)),
               randBits(5) + 2, randBits(4));
        injectError = 1'b0;
        errModel = 1'b1;
        ciAccess("error status", ciPkg::selCtrlStatus, 1'b0, '0, '0);
        ciAccess("error clear", ciPkg::selCtrlStatus, 1'b1, '0, '0);
        ciAccess("status after clear", ciPkg::selCtrlStatus, 1'b0, '0, '0);

        repeat (3) @(posedge clock);
        chk.printCounts();
        if (chk.errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // three blocks of up to 64 words and about 600 CPU instructions
    initial begin : watchdog
        int limit;
        limit = 200 * 3 * 64 + 20 * 600;
        repeat (limit) @(posedge clock);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: compile.f
logic/ciPkg.sv
logic/busPkg.sv
logic/dualPortSsram.sv
logic/dmaRegisters.sv
logic/dmaBusMaster.sv
logic/ramDmaCi.sv
sim/tbClock.sv
sim/ramDmaCiChecker.sv
sim/ramDmaCiTb.sv
